// ==== rtl/bridge_defs.svh ====
//##########################################################
// bridge parameters
// sizes of the dual-clock sample FIFO and the stream fields.
//##########################################################
`ifndef BRIDGE_DEFS_SVH
`define BRIDGE_DEFS_SVH

`define BRIDGE_FIFO_DEPTH  16   // entries, power of two.
`define BRIDGE_SYNC_STAGES 2    // flops per pointer crossing.

`define BRIDGE_DATA_W      16   // sample payload.
`define BRIDGE_CHAN_W      4    // channel tag.
`define BRIDGE_SEQ_W       8    // sequence number, wraps.

// free entries left at a_full, also the a_empty fill level.
`define BRIDGE_FULL_MARGIN 2

`endif

// ==== rtl/fifo_pkg.sv ====
//##########################################################
// fifo types
// pointer, address and status flag types of the async FIFO.
//##########################################################
`include "bridge_defs.svh"

package fifo_pkg;

    localparam int ADDR_W = $clog2(`BRIDGE_FIFO_DEPTH);
    localparam int PTR_W  = ADDR_W + 1;   // extra wrap bit.

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [PTR_W-1:0]  ptr_t;

    typedef struct packed {
        logic full;
        logic a_full;
    } wr_status_t;

    typedef struct packed {
        logic empty;
        logic a_empty;
    } rd_status_t;

    // gray code back to binary, msb first.
    function automatic ptr_t gray2bin(ptr_t gray);
        ptr_t bin;
        bin[PTR_W-1] = gray[PTR_W-1];
        for (int i = PTR_W - 2; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

endpackage

// ==== rtl/stream_pkg.sv ====
//##########################################################
// stream types
// sample, framed FIFO entry and output word of the bridge.
//##########################################################
`include "bridge_defs.svh"

package stream_pkg;

    typedef logic [`BRIDGE_SEQ_W-1:0] seq_t;

    typedef struct packed {
        logic [`BRIDGE_CHAN_W-1:0] chan;
        logic [`BRIDGE_DATA_W-1:0] data;
    } sample_t;

    // what travels through the FIFO.
    typedef struct packed {
        seq_t    seq;
        sample_t sample;
    } entry_t;

    typedef struct packed {
        entry_t entry;
        logic   gap;   // seq did not follow the previous one.
    } out_t;

endpackage

// ==== rtl/sample_framer.sv ====
//##########################################################
// sample framer
// write side input stage. stamps each strobe with a sequence
// number, pushes while the FIFO has room and counts drops.
//##########################################################
`timescale 1ns/10ps

module sample_framer (
    input  logic                   wr_clk_i,
    input  logic                   arst_n_i,
    input  logic                   sample_valid_i,
    input  stream_pkg::sample_t    sample_i,
    input  fifo_pkg::wr_status_t   wr_status_i,
    output logic                   push_o,
    output stream_pkg::entry_t     entry_o,
    output logic [15:0]            drop_cnt_o
);

    stream_pkg::seq_t seq_q;
    logic             drop;

    assign push_o = sample_valid_i & ~wr_status_i.full;
    assign drop   = sample_valid_i &  wr_status_i.full;

    always_comb begin
        entry_o.seq    = seq_q;
        entry_o.sample = sample_i;
    end

    // seq advances on every strobe, dropped or not.
    always_ff @(posedge wr_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            seq_q <= '0;
        end else if (sample_valid_i) begin
            seq_q <= seq_q + 1'b1;
        end
    end

    always_ff @(posedge wr_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            drop_cnt_o <= '0;
        end else if (drop && !(&drop_cnt_o)) begin   // saturates.
            drop_cnt_o <= drop_cnt_o + 1'b1;
        end
    end

endmodule

// ==== rtl/ptr_sync.sv ====
//##########################################################
// pointer synchronizer
// flop chain carrying a gray pointer into the clock domain
// of clk_i.
//##########################################################
`timescale 1ns/10ps
`include "bridge_defs.svh"

module ptr_sync (
    input  logic           clk_i,
    input  logic           arst_n_i,
    input  fifo_pkg::ptr_t ptr_i,
    output fifo_pkg::ptr_t ptr_o
);

    localparam int STAGES = `BRIDGE_SYNC_STAGES;

    fifo_pkg::ptr_t [STAGES-1:0] sync_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sync_q <= '0;
        end else begin
            sync_q[0] <= ptr_i;   // first stage may go metastable.
            for (int i = 1; i < STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign ptr_o = sync_q[STAGES-1];

endmodule

// ==== rtl/wr_ptr_full.sv ====
//##########################################################
// write pointer and full
// binary and gray write pointers, registered full and
// almost-full against the synchronized read pointer.
//##########################################################
`timescale 1ns/10ps
`include "bridge_defs.svh"

module wr_ptr_full (
    input  logic                 wr_clk_i,
    input  logic                 arst_n_i,
    input  logic                 push_i,
    input  fifo_pkg::ptr_t       rd_ptr_sync_i,
    output fifo_pkg::addr_t      wr_addr_o,
    output fifo_pkg::ptr_t       wr_ptr_o,
    output fifo_pkg::wr_status_t wr_status_o
);

    localparam int PTR_W = fifo_pkg::PTR_W;

    fifo_pkg::ptr_t wr_bin_q;
    fifo_pkg::ptr_t wr_bin_next;
    fifo_pkg::ptr_t wr_gray_next;
    fifo_pkg::ptr_t rd_bin_sync;
    fifo_pkg::ptr_t fill_next;
    logic           full_next;
    logic           a_full_next;

    assign wr_bin_next  = wr_bin_q + fifo_pkg::ptr_t'(push_i & ~wr_status_o.full);
    assign wr_gray_next = (wr_bin_next >> 1) ^ wr_bin_next;
    assign rd_bin_sync  = fifo_pkg::gray2bin(rd_ptr_sync_i);
    assign fill_next    = wr_bin_next - rd_bin_sync;

    // full when pointers differ only in the two msbs.
    assign full_next = (wr_gray_next ==
                        {~rd_ptr_sync_i[PTR_W-1 -: 2], rd_ptr_sync_i[PTR_W-3:0]});
    assign a_full_next = (fill_next >=
                          fifo_pkg::ptr_t'(`BRIDGE_FIFO_DEPTH - `BRIDGE_FULL_MARGIN));

    always_ff @(posedge wr_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_bin_q    <= '0;
            wr_ptr_o    <= '0;
            wr_status_o <= '0;
        end else begin
            wr_bin_q           <= wr_bin_next;
            wr_ptr_o           <= wr_gray_next;
            wr_status_o.full   <= full_next;
            wr_status_o.a_full <= a_full_next;
        end
    end

    assign wr_addr_o = wr_bin_q[fifo_pkg::ADDR_W-1:0];

endmodule

// ==== rtl/rd_ptr_empty.sv ====
//##########################################################
// read pointer and empty
// binary and gray read pointers, registered empty and
// almost-empty against the synchronized write pointer.
//##########################################################
`timescale 1ns/10ps
`include "bridge_defs.svh"

module rd_ptr_empty (
    input  logic                 rd_clk_i,
    input  logic                 arst_n_i,
    input  logic                 pop_i,
    input  fifo_pkg::ptr_t       wr_ptr_sync_i,
    output fifo_pkg::addr_t      rd_addr_o,
    output fifo_pkg::ptr_t       rd_ptr_o,
    output fifo_pkg::rd_status_t rd_status_o
);

    fifo_pkg::ptr_t rd_bin_q;
    fifo_pkg::ptr_t rd_bin_next;
    fifo_pkg::ptr_t rd_gray_next;
    fifo_pkg::ptr_t wr_bin_sync;
    fifo_pkg::ptr_t fill_next;
    logic           empty_next;
    logic           a_empty_next;

    assign rd_bin_next  = rd_bin_q + fifo_pkg::ptr_t'(pop_i & ~rd_status_o.empty);
    assign rd_gray_next = (rd_bin_next >> 1) ^ rd_bin_next;
    assign wr_bin_sync  = fifo_pkg::gray2bin(wr_ptr_sync_i);
    assign fill_next    = wr_bin_sync - rd_bin_next;

    assign empty_next   = (rd_gray_next == wr_ptr_sync_i);   // caught up.
    assign a_empty_next = (fill_next <= fifo_pkg::ptr_t'(`BRIDGE_FULL_MARGIN));

    //##########################################################
    // pointers and flags, empty after reset.
    //##########################################################
    always_ff @(posedge rd_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_bin_q    <= '0;
            rd_ptr_o    <= '0;
            rd_status_o <= '1;
        end else begin
            rd_bin_q            <= rd_bin_next;
            rd_ptr_o            <= rd_gray_next;
            rd_status_o.empty   <= empty_next;
            rd_status_o.a_empty <= a_empty_next;
        end
    end

    assign rd_addr_o = rd_bin_q[fifo_pkg::ADDR_W-1:0];

endmodule

// ==== rtl/async_fifo.sv ====
//##########################################################
// async fifo
// dual-clock FIFO with gray pointers crossing through flop
// synchronizers. payload type is a parameter, read data is
// registered on pop.
//##########################################################
`timescale 1ns/10ps
`include "bridge_defs.svh"

module async_fifo #(
    parameter type T_PAYLOAD = logic [7:0]
) (
    input  logic                 wr_clk_i,
    input  logic                 rd_clk_i,
    input  logic                 arst_n_i,
    input  logic                 push_i,
    input  T_PAYLOAD             wr_data_i,
    output fifo_pkg::wr_status_t wr_status_o,
    input  logic                 pop_i,
    output T_PAYLOAD             rd_data_o,
    output fifo_pkg::rd_status_t rd_status_o
);

    fifo_pkg::addr_t wr_addr;
    fifo_pkg::addr_t rd_addr;
    fifo_pkg::ptr_t  wr_ptr;
    fifo_pkg::ptr_t  rd_ptr;
    fifo_pkg::ptr_t  wr_ptr_sync;   // in rd_clk_i domain.
    fifo_pkg::ptr_t  rd_ptr_sync;   // in wr_clk_i domain.
    logic            wr_en;
    logic            rd_en;

    T_PAYLOAD mem_q [`BRIDGE_FIFO_DEPTH];

    assign wr_en = push_i & ~wr_status_o.full;
    assign rd_en = pop_i  & ~rd_status_o.empty;

    wr_ptr_full i_wr_ptr_full (
        .wr_clk_i     (wr_clk_i),
        .arst_n_i     (arst_n_i),
        .push_i       (push_i),
        .rd_ptr_sync_i(rd_ptr_sync),
        .wr_addr_o    (wr_addr),
        .wr_ptr_o     (wr_ptr),
        .wr_status_o  (wr_status_o)
    );

    rd_ptr_empty i_rd_ptr_empty (
        .rd_clk_i     (rd_clk_i),
        .arst_n_i     (arst_n_i),
        .pop_i        (pop_i),
        .wr_ptr_sync_i(wr_ptr_sync),
        .rd_addr_o    (rd_addr),
        .rd_ptr_o     (rd_ptr),
        .rd_status_o  (rd_status_o)
    );

    ptr_sync i_wr_ptr_sync (
        .clk_i   (rd_clk_i),
        .arst_n_i(arst_n_i),
        .ptr_i   (wr_ptr),
        .ptr_o   (wr_ptr_sync)
    );

    ptr_sync i_rd_ptr_sync (
        .clk_i   (wr_clk_i),
        .arst_n_i(arst_n_i),
        .ptr_i   (rd_ptr),
        .ptr_o   (rd_ptr_sync)
    );

    //##########################################################
    // two-port memory
    //##########################################################
    always_ff @(posedge wr_clk_i) begin
        if (wr_en) begin
            mem_q[wr_addr] <= wr_data_i;
        end
    end

    always_ff @(posedge rd_clk_i) begin
        if (rd_en) begin
            rd_data_o <= mem_q[rd_addr];   // holds until next pop.
        end
    end

endmodule

// ==== rtl/sample_unframer.sv ====
//##########################################################
// sample unframer
// read side output stage. pops while enabled, flags the
// popped entry one cycle later and checks seq continuity.
//##########################################################
`timescale 1ns/10ps

module sample_unframer (
    input  logic                 rd_clk_i,
    input  logic                 arst_n_i,
    input  logic                 rd_en_i,
    input  fifo_pkg::rd_status_t rd_status_i,
    input  stream_pkg::entry_t   entry_i,
    output logic                 pop_o,
    output logic                 out_valid_o,
    output stream_pkg::out_t     out_o
);

    stream_pkg::seq_t exp_seq_q;   // seq expected on next output.

    assign pop_o = rd_en_i & ~rd_status_i.empty;

    // read data lands one cycle after the pop.
    always_ff @(posedge rd_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out_valid_o <= 1'b0;
        end else begin
            out_valid_o <= pop_o;
        end
    end

    always_comb begin
        out_o.entry = entry_i;
        out_o.gap   = (entry_i.seq != exp_seq_q);
    end

    // follow the stream, so one gap flags only once.
    always_ff @(posedge rd_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            exp_seq_q <= '0;
        end else if (out_valid_o) begin
            exp_seq_q <= entry_i.seq + 1'b1;
        end
    end

endmodule

// ==== rtl/cdc_sample_bridge.sv ====
//##########################################################
// cdc sample bridge
// carries tagged samples from the write clock to the read
// clock through the async FIFO. drops on full are counted
// and show up as gaps in the output seq.
//##########################################################
`timescale 1ns/10ps

module cdc_sample_bridge (
    input  logic                wr_clk_i,
    input  logic                rd_clk_i,
    input  logic                arst_n_i,
    input  logic                sample_valid_i,
    input  stream_pkg::sample_t sample_i,
    output logic [15:0]         drop_cnt_o,
    output logic                a_full_o,
    input  logic                rd_en_i,
    output logic                out_valid_o,
    output stream_pkg::out_t    out_o
);

    logic                 push;
    logic                 pop;
    stream_pkg::entry_t   wr_entry;
    stream_pkg::entry_t   rd_entry;
    fifo_pkg::wr_status_t wr_status;
    fifo_pkg::rd_status_t rd_status;

    assign a_full_o = wr_status.a_full;

    sample_framer i_sample_framer (
        .wr_clk_i      (wr_clk_i),
        .arst_n_i      (arst_n_i),
        .sample_valid_i(sample_valid_i),
        .sample_i      (sample_i),
        .wr_status_i   (wr_status),
        .push_o        (push),
        .entry_o       (wr_entry),
        .drop_cnt_o    (drop_cnt_o)
    );

    async_fifo #(
        .T_PAYLOAD(stream_pkg::entry_t)
    ) i_async_fifo (
        .wr_clk_i   (wr_clk_i),
        .rd_clk_i   (rd_clk_i),
        .arst_n_i   (arst_n_i),
        .push_i     (push),
        .wr_data_i  (wr_entry),
        .wr_status_o(wr_status),
        .pop_i      (pop),
        .rd_data_o  (rd_entry),
        .rd_status_o(rd_status)
    );

    sample_unframer i_sample_unframer (
        .rd_clk_i   (rd_clk_i),
        .arst_n_i   (arst_n_i),
        .rd_en_i    (rd_en_i),
        .rd_status_i(rd_status),
        .entry_i    (rd_entry),
        .pop_o      (pop),
        .out_valid_o(out_valid_o),
        .out_o      (out_o)
    );

endmodule

// ==== test/tb_cdc_sample_bridge.sv ====
//##########################################################
// cdc sample bridge testbench
// replays test records from the data file, models the
// expected output stream and checks the DUT results.
//##########################################################
`timescale 1ns/10ps
`include "bridge_defs.svh"

module tb_cdc_sample_bridge;

    logic                wr_clk_i;
    logic                rd_clk_i;
    logic                arst_n_i;
    logic                sample_valid_i;
    stream_pkg::sample_t sample_i;
    logic [15:0]         drop_cnt_o;
    logic                a_full_o;
    logic                rd_en_i;
    logic                out_valid_o;
    stream_pkg::out_t    out_o;

    string            rec_name[$];
    string            rec_mode[$];
    int               rec_count[$];
    logic [15:0]      rec_base[$];
    logic [3:0]       rec_chan[$];
    logic             rec_flag[$];
    logic [15:0]      rec_drops[$];

    stream_pkg::out_t exp_q[$];
    stream_pkg::seq_t m_seq;   // write side seq model.
    stream_pkg::seq_t m_exp;   // seq the output side expects next.
    int               m_fill;
    string            cur_name;
    int               errors;
    int               tests_passed;
    int               tests_failed;
    int               rx_count;
    int               cycle_cnt;
    int               cycle_limit;
    integer           seed;
    bit               file_ok;

    cdc_sample_bridge uut (
        .wr_clk_i      (wr_clk_i),
        .rd_clk_i      (rd_clk_i),
        .arst_n_i      (arst_n_i),
        .sample_valid_i(sample_valid_i),
        .sample_i      (sample_i),
        .drop_cnt_o    (drop_cnt_o),
        .a_full_o      (a_full_o),
        .rd_en_i       (rd_en_i),
        .out_valid_o   (out_valid_o),
        .out_o         (out_o)
    );

    always #10 wr_clk_i = ~wr_clk_i;
    always #14 rd_clk_i = ~rd_clk_i;   // unrelated to the write clock.

    //##########################################################
    // compare tasks
    //##########################################################
    task automatic check_out(input string name, input stream_pkg::out_t exp,
                             input stream_pkg::out_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input logic [15:0] exp,
                               input logic [15:0] act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic load_records(output bit ok);
        int          fd;
        int          n;
        string       line;
        string       name;
        string       mode;
        int          cnt;
        logic [15:0] base;
        logic [3:0]  chan;
        int          flag;
        int          drops;
        ok = 1'b0;
        fd = $fopen("test/bridge_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open the test data file");
            return;
        end
        while (!$feof(fd)) begin
            if ($fgets(line, fd) == 0) break;
            if (line.len() < 2 || line.substr(0, 0) == "#") continue;
            n = $sscanf(line, "%s %s %d %h %h %d %d", name, mode, cnt, base, chan,
                        flag, drops);
            if (n != 7) begin
                $display("malformed test data record: %s", line);
                $fclose(fd);
                return;
            end
            rec_name.push_back(name);
            rec_mode.push_back(mode);
            rec_count.push_back(cnt);
            rec_base.push_back(base);
            rec_chan.push_back(chan);
            rec_flag.push_back(flag[0]);
            rec_drops.push_back(16'(drops));
        end
        $fclose(fd);
        ok = (rec_name.size() > 0);
    endtask

    // one strobe, plus the model of accept or drop.
    task automatic drive_strobe(input logic [15:0] data, input logic [3:0] chan,
                                input bit may_drop);
        stream_pkg::out_t e;
        @(posedge wr_clk_i);
        sample_valid_i <= 1'b1;
        sample_i.chan  <= chan;
        sample_i.data  <= data;
        if (!may_drop || m_fill < `BRIDGE_FIFO_DEPTH) begin
            e.entry.seq         = m_seq;
            e.entry.sample.chan = chan;
            e.entry.sample.data = data;
            e.gap               = (m_seq != m_exp);
            exp_q.push_back(e);
            m_exp = m_seq + stream_pkg::seq_t'(1);
            if (may_drop) begin
                m_fill++;
            end
        end
        m_seq = m_seq + stream_pkg::seq_t'(1);   // dropped strobes count too.
    endtask

    task automatic run_record(input int idx);
        int          err_start;
        int          rx_start;
        int unsigned gap;
        cur_name  = rec_name[idx];
        err_start = errors;
        if (rec_mode[idx] == "reset") begin
            @(posedge rd_clk_i);
            rd_en_i <= 1'b0;
            @(posedge wr_clk_i);
            arst_n_i       <= 1'b0;
            sample_valid_i <= 1'b0;
            exp_q.delete();
            m_seq  = '0;
            m_exp  = '0;
            m_fill = 0;
            repeat (8) @(posedge wr_clk_i);
            arst_n_i <= 1'b1;
            @(negedge wr_clk_i);
            check_flag(cur_name, 1'b0, out_valid_o);
            check_flag(cur_name, rec_flag[idx], a_full_o);
            check_count(cur_name, rec_drops[idx], drop_cnt_o);
        end else if (rec_mode[idx] == "stream") begin
            @(posedge rd_clk_i);
            rd_en_i <= 1'b1;
            for (int i = 0; i < rec_count[idx]; i++) begin
                drive_strobe(rec_base[idx] + 16'(i), rec_chan[idx], 1'b0);
                @(posedge wr_clk_i);
                sample_valid_i <= 1'b0;
                gap = $unsigned($random(seed)) % 4;
                repeat (gap) @(posedge wr_clk_i);
            end
            while (exp_q.size() > 0) @(posedge rd_clk_i);
            repeat (8) @(posedge wr_clk_i);   // read pointer reaches the write side.
            @(negedge wr_clk_i);
            check_count(cur_name, rec_drops[idx], drop_cnt_o);
        end else if (rec_mode[idx] == "fill") begin
            @(posedge rd_clk_i);
            rd_en_i <= 1'b0;
            for (int i = 0; i < rec_count[idx]; i++) begin
                drive_strobe(rec_base[idx] + 16'(i), rec_chan[idx], 1'b1);
            end
            @(posedge wr_clk_i);
            sample_valid_i <= 1'b0;
            @(negedge wr_clk_i);
            check_flag(cur_name, rec_flag[idx], a_full_o);
            check_count(cur_name, rec_drops[idx], drop_cnt_o);
        end else if (rec_mode[idx] == "drain") begin
            rx_start = rx_count;
            @(posedge rd_clk_i);
            rd_en_i <= 1'b1;
            while (rx_count - rx_start < rec_count[idx]) @(posedge rd_clk_i);
            repeat (12) @(posedge rd_clk_i);   // room for any extra entry.
            check_count(cur_name, 16'(rec_count[idx]), 16'(rx_count - rx_start));
            m_fill = 0;
            repeat (8) @(posedge wr_clk_i);
        end else begin
            $display("unknown mode %s in test record %s", rec_mode[idx], cur_name);
            errors++;
        end
        if (errors == err_start) begin
            tests_passed++;
            $display("test %s passed", cur_name);
        end else begin
            tests_failed++;
            $display("test %s failed", cur_name);
        end
    endtask

    //##########################################################
    // output monitor and run limit
    //##########################################################
    always @(negedge rd_clk_i) begin
        if (arst_n_i && out_valid_o) begin
            rx_count++;
            if (exp_q.size() == 0) begin
                $display("test %s got an output word when none was expected", cur_name);
                errors++;
            end else begin
                check_out(cur_name, exp_q.pop_front(), out_o);
            end
        end
    end

    always @(posedge wr_clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout, the run did not end within %0d write cycles", cycle_limit);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        wr_clk_i       = 1'b0;
        rd_clk_i       = 1'b0;
        arst_n_i       = 1'b0;
        sample_valid_i = 1'b0;
        sample_i       = '0;
        rd_en_i        = 1'b0;
        m_seq          = '0;
        m_exp          = '0;
        m_fill         = 0;
        errors         = 0;
        tests_passed   = 0;
        tests_failed   = 0;
        rx_count       = 0;
        cycle_cnt      = 0;
        cycle_limit    = 0;
        seed           = 99;
        load_records(file_ok);
        if (!file_ok) begin
            $display("no usable test records were read");
            errors++;
        end else begin
            cycle_limit = 500;
            foreach (rec_count[i]) cycle_limit += rec_count[i] * 40;
            for (int i = 0; i < rec_name.size(); i++) begin
                run_record(i);
            end
        end
        $display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
        if (errors == 0 && tests_failed == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== test/bridge_testdata.txt ====
# columns: name mode count data_base(hex) chan(hex) exp_flag exp_drops
# exp_flag is a_full for reset and fill, exp_drops is drop_cnt_o after the test.
# count is strobes for stream and fill, and entries out for drain.
#
# state right after reset
after_reset reset 0 0000 0 0 0
# 40 samples with the reader running
stream40 stream 40 1000 3 0 0
#
# fill with reads stalled, then overflow
fill_reset reset 0 0000 0 0 0
fill13 fill 13 2000 5 0 0
fill14 fill 1 200d 5 1 0
overflow fill 6 200e 5 1 4
#
# drain the full FIFO, then one new strobe after the dropped ones
drain drain 16 0000 0 0 0
gap_after stream 1 3000 7 0 4
#
# long stream past the seq wrap
seq_wrap stream 260 4000 9 0 4

// ==== files.f ====
+incdir+rtl
rtl/fifo_pkg.sv
rtl/stream_pkg.sv
rtl/sample_framer.sv
rtl/ptr_sync.sv
rtl/wr_ptr_full.sv
rtl/rd_ptr_empty.sv
rtl/async_fifo.sv
rtl/sample_unframer.sv
rtl/cdc_sample_bridge.sv
test/tb_cdc_sample_bridge.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -sv -Wno-fatal
TOP       = tb_cdc_sample_bridge
FILELIST  = files.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^NO ERRORS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
